// ==== reg_renamer.f ====
hdl/rename_pkg.sv
hdl/free_list_if.sv
hdl/rename_ctrl.sv
hdl/phys_free_list.sv
hdl/spec_map_table.sv
hdl/inflight_table.sv
hdl/reg_renamer.sv
testbench/tb_clock_gen.sv
testbench/tb_reg_renamer.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_reg_renamer
FILELIST := reg_renamer.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_reg_renamer.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the register renaming block.
// Plays decode, issue and retire around the DUT. A queue-based model of
// the map and free list predicts every rename lookup, and a compare
// process checks the DUT on each falling edge. Directed tests cover
// init, rename, commit, revert and rollback, then a seeded random run.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_reg_renamer;
    import rename_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY = 2;
    localparam int SEED = 84169;
    // Stimulus cycles per test, upper bounds
    localparam int INIT_CYCLES = 22;
    localparam int RENAME_CYCLES = 8;
    localparam int COMMIT_CYCLES = 90;
    localparam int REVERT_CYCLES = 6;
    localparam int ROLLBACK_CYCLES = 8;
    localparam int RANDOM_CYCLES = 300;
    localparam int DRAIN_CYCLES = MAX_IDS + 2;
    localparam int STIM_CYCLES = INIT_CYCLES + RENAME_CYCLES + COMMIT_CYCLES
                               + REVERT_CYCLES + ROLLBACK_CYCLES + RANDOM_CYCLES
                               + DRAIN_CYCLES;
    // Reset, init walk and stimulus, plus 100 cycles of slack
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_ARCH_REGS + STIM_CYCLES + 100)
                               * CLK_PERIOD;

    logic clk;
    logic arst_n;
    logic init_done;
    logic decode_advance;
    logic decode_uses_rd;
    arch_addr_t decode_rd_addr;
    arch_addr_t decode_rs_addr [NUM_READ_PORTS];
    phys_addr_t decode_phys_rs_addr [NUM_READ_PORTS];
    phys_addr_t decode_phys_rd_addr;
    logic issue_valid;
    logic issue_with_rd;
    id_t issue_id;
    arch_addr_t issue_rd_addr;
    phys_addr_t issue_phys_rd_addr;
    logic flush;
    logic retire_valid;
    id_t retire_id;
    logic retire_revert;

    // Reference model state
    phys_addr_t map_model [NUM_ARCH_REGS];
    phys_addr_t free_q [$];
    inflight_entry_t rec_model [MAX_IDS];
    phys_addr_t prev_model;
    phys_addr_t last_pop;
    int init_steps = 0;

    // Issued ids awaiting retire, oldest first
    id_t retire_q [$];
    id_t next_id = '0;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_start = 0;
    string cur_test = "reset";

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    reg_renamer reg_renamer_inst (
        .clk                 (clk),
        .arst_n              (arst_n),
        .init_done           (init_done),
        .decode_advance      (decode_advance),
        .decode_uses_rd      (decode_uses_rd),
        .decode_rd_addr      (decode_rd_addr),
        .decode_rs_addr      (decode_rs_addr),
        .decode_phys_rs_addr (decode_phys_rs_addr),
        .decode_phys_rd_addr (decode_phys_rd_addr),
        .issue_valid         (issue_valid),
        .issue_with_rd       (issue_with_rd),
        .issue_id            (issue_id),
        .issue_rd_addr       (issue_rd_addr),
        .issue_phys_rd_addr  (issue_phys_rd_addr),
        .flush               (flush),
        .retire_valid        (retire_valid),
        .retire_id           (retire_id),
        .retire_revert       (retire_revert)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Expected lookup; a destination takes the free list head, x0 gets p0
    function automatic phys_addr_t ref_rename(input arch_addr_t addr, input logic is_dest);
        if (!is_dest) begin
            return map_model[addr];
        end
        if (addr == '0 || free_q.size() == 0) begin
            return '0;
        end
        return free_q[0];
    endfunction

    // One clock edge of the renamer as the block is specified
    task automatic model_step();
        inflight_entry_t rec;
        phys_addr_t old;
        if (init_steps < NUM_ARCH_REGS) begin
            // Identity map and free registers 32..63, inputs ignored
            map_model[init_steps] = phys_addr_t'(init_steps);
            free_q.push_back(phys_addr_t'(init_steps + NUM_ARCH_REGS));
            init_steps++;
            return;
        end
        // Retire sees the record as it stood before this edge
        rec = rec_model[retire_id];
        if (issue_with_rd) begin
            rec_model[issue_id] = '{rd_addr: issue_rd_addr, spec_phys: issue_phys_rd_addr,
                                    prev_phys: prev_model};
        end
        if (retire_valid) begin
            free_q.push_back(retire_revert ? rec.spec_phys : rec.prev_phys);
        end
        // Map writes by priority: rollback, revert, rename
        if (flush && issue_valid && issue_rd_addr != '0) begin
            old = map_model[issue_rd_addr];
            map_model[issue_rd_addr] = prev_model;
            prev_model = old;
            free_q.push_front(last_pop);
        end else if (retire_valid && retire_revert) begin
            old = map_model[rec.rd_addr];
            map_model[rec.rd_addr] = rec.prev_phys;
            prev_model = old;
        end else if (decode_advance && decode_uses_rd && decode_rd_addr != '0) begin
            old = map_model[decode_rd_addr];
            last_pop = free_q.pop_front();
            map_model[decode_rd_addr] = last_pop;
            prev_model = old;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            model_step();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and per-cycle check

    task automatic check_phys(input string what, input phys_addr_t exp, input phys_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: test %s, %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: test %s, %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            check_flag("init_done", init_steps == NUM_ARCH_REGS, init_done);
            if (init_steps == NUM_ARCH_REGS) begin
                for (int i = 0; i < NUM_READ_PORTS; i++) begin
                    check_phys($sformatf("phys_rs%0d", i),
                               ref_rename(decode_rs_addr[i], 1'b0), decode_phys_rs_addr[i]);
                end
                check_phys("phys_rd", ref_rename(decode_rd_addr, 1'b1), decode_phys_rd_addr);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Next drive slot, all strobes idle
    task automatic step();
        @(posedge clk);
        #(DRIVE_DELAY);
        decode_advance = 1'b0;
        decode_uses_rd = 1'b0;
        issue_valid = 1'b0;
        issue_with_rd = 1'b0;
        flush = 1'b0;
        retire_valid = 1'b0;
        retire_revert = 1'b0;
    endtask

    task automatic decode_op(input arch_addr_t rd, input arch_addr_t rs0, input arch_addr_t rs1,
                             input phys_addr_t exp_rd);
        step();
        decode_advance = 1'b1;
        decode_uses_rd = 1'b1;
        decode_rd_addr = rd;
        decode_rs_addr[0] = rs0;
        decode_rs_addr[1] = rs1;
        @(negedge clk);
        check_phys("renamed rd", exp_rd, decode_phys_rd_addr);
    endtask

    task automatic issue_op(input id_t id, input arch_addr_t rd, input phys_addr_t phys);
        step();
        issue_valid = 1'b1;
        issue_with_rd = 1'b1;
        issue_id = id;
        issue_rd_addr = rd;
        issue_phys_rd_addr = phys;
    endtask

    task automatic retire_op(input id_t id, input logic revert);
        step();
        retire_valid = 1'b1;
        retire_id = id;
        retire_revert = revert;
    endtask

    task automatic read_check(input arch_addr_t rs0, input arch_addr_t rs1,
                              input phys_addr_t exp0, input phys_addr_t exp1);
        step();
        decode_rs_addr[0] = rs0;
        decode_rs_addr[1] = rs1;
        @(negedge clk);
        check_phys("source 0", exp0, decode_phys_rs_addr[0]);
        check_phys("source 1", exp1, decode_phys_rs_addr[1]);
    endtask

    // Issue stage of the random run; only a real rd gets a record
    task automatic issue_pending(input arch_addr_t rd, input phys_addr_t phys);
        issue_valid = 1'b1;
        issue_rd_addr = rd;
        if (rd != '0) begin
            issue_with_rd = 1'b1;
            issue_id = next_id;
            issue_phys_rd_addr = phys;
            retire_q.push_back(next_id);
            next_id = next_id + 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
        end else begin
            $display("test %s ok", cur_test);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic test_init();
        int n;
        begin_test("init");
        n = 0;
        @(posedge arst_n);
        while (init_done !== 1'b1 && n < 2 * NUM_ARCH_REGS) begin
            @(negedge clk);
            n++;
        end
        if (init_done !== 1'b1) begin
            errors++;
            $display("init_done did not rise within %0d cycles of reset", n);
        end else if (n != NUM_ARCH_REGS) begin
            errors++;
            $display("error: test init, cycles to init_done expected %0d actual %0d",
                     NUM_ARCH_REGS, n);
        end
        // Identity map, two registers per cycle
        for (int a = 0; a < NUM_ARCH_REGS / 2; a++) begin
            read_check(arch_addr_t'(a), arch_addr_t'(a + 16),
                       phys_addr_t'(a), phys_addr_t'(a + 16));
        end
        // Free list hands out 32, 33, 34 in order
        for (int k = 0; k < 3; k++) begin
            decode_op(arch_addr_t'(k + 1), '0, '0, phys_addr_t'(32 + k));
            issue_op(id_t'(k), arch_addr_t'(k + 1), phys_addr_t'(32 + k));
        end
        end_test();
    endtask

    task automatic test_rename();
        begin_test("rename");
        decode_op(5'd5, 5'd5, 5'd0, 6'd35);
        issue_op(4'd3, 5'd5, 6'd35);
        read_check(5'd5, 5'd1, 6'd35, 6'd32);
        // x0 destination takes nothing
        decode_op(5'd0, 5'd0, 5'd0, 6'd0);
        decode_op(5'd6, 5'd6, 5'd0, 6'd36);
        issue_op(4'd4, 5'd6, 6'd36);
        end_test();
    endtask

    task automatic test_commit();
        phys_addr_t exp;
        begin_test("commit");
        // Old mappings 1, 2, 3, 5, 6 go to the tail
        for (int i = 0; i < 5; i++) begin
            retire_op(id_t'(i), 1'b0);
        end
        // Rest of the original pool comes first, then p1
        for (int k = 0; k < 28; k++) begin
            exp = (k < 27) ? phys_addr_t'(37 + k) : 6'd1;
            decode_op(5'd7, 5'd7, 5'd0, exp);
            issue_op(4'd5, 5'd7, exp);
            retire_op(4'd5, 1'b0);
        end
        end_test();
    endtask

    task automatic test_revert();
        begin_test("revert");
        decode_op(5'd8, 5'd8, 5'd0, 6'd2);
        issue_op(4'd6, 5'd8, 6'd2);
        retire_op(4'd6, 1'b1);
        read_check(5'd8, 5'd7, 6'd8, 6'd1);
        end_test();
    endtask

    task automatic test_rollback();
        begin_test("rollback");
        // p2 went to the tail on revert, so p3 is next
        decode_op(5'd9, 5'd9, 5'd0, 6'd3);
        // Flush with x9 in issue; the rename of x10 is dropped
        step();
        flush = 1'b1;
        issue_valid = 1'b1;
        issue_rd_addr = 5'd9;
        decode_advance = 1'b1;
        decode_uses_rd = 1'b1;
        decode_rd_addr = 5'd10;
        read_check(5'd9, 5'd10, 6'd9, 6'd10);
        decode_op(5'd10, 5'd10, 5'd9, 6'd3);
        issue_op(4'd7, 5'd10, 6'd3);
        retire_op(4'd7, 1'b0);
        end_test();
    endtask

    task automatic test_random();
        logic do_retire;
        logic pend_valid;
        arch_addr_t pend_rd;
        phys_addr_t pend_phys;
        begin_test("random");
        pend_valid = 1'b0;
        pend_rd = '0;
        pend_phys = '0;
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            step();
            // Retire only ids issued in earlier cycles
            do_retire = (retire_q.size() > 0)
                      && (($urandom_range(2, 0) == 0) || (retire_q.size() >= MAX_IDS - 2));
            if (do_retire) begin
                retire_valid = 1'b1;
                retire_id = retire_q.pop_front();
            end
            if (pend_valid) begin
                issue_pending(pend_rd, pend_phys);
            end
            pend_valid = 1'b0;
            decode_rs_addr[0] = arch_addr_t'($urandom_range(31, 0));
            decode_rs_addr[1] = arch_addr_t'($urandom_range(31, 0));
            // No decode beside a retire or when ids run short
            if (!do_retire && retire_q.size() < MAX_IDS - 2 && $urandom_range(3, 0) != 0) begin
                decode_advance = 1'b1;
                decode_uses_rd = ($urandom_range(7, 0) != 0);
                decode_rd_addr = arch_addr_t'($urandom_range(31, 0));
                pend_valid = 1'b1;
                pend_rd = decode_uses_rd ? decode_rd_addr : '0;
                pend_phys = ref_rename(decode_rd_addr, 1'b1);
            end
        end
        // Drain the issue stage, then commit the rest in order
        while (pend_valid || retire_q.size() > 0) begin
            step();
            if (pend_valid) begin
                issue_pending(pend_rd, pend_phys);
                pend_valid = 1'b0;
            end else begin
                retire_valid = 1'b1;
                retire_id = retire_q.pop_front();
            end
        end
        step();
        end_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        decode_advance = 1'b0;
        decode_uses_rd = 1'b0;
        decode_rd_addr = '0;
        decode_rs_addr[0] = '0;
        decode_rs_addr[1] = '0;
        issue_valid = 1'b0;
        issue_with_rd = 1'b0;
        issue_id = '0;
        issue_rd_addr = '0;
        issue_phys_rd_addr = '0;
        flush = 1'b0;
        retire_valid = 1'b0;
        retire_id = '0;
        retire_revert = 1'b0;
        prev_model = '0;
        last_pop = '0;
        void'($urandom(SEED));

        test_init();
        test_rename();
        test_commit();
        test_revert();
        test_rollback();
        test_random();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, test %s did not finish", WATCHDOG_NS, cur_test);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Clock and reset source for the renamer testbench.
// Free-running clock; reset held low for RESET_CYCLES rising edges and
// released on a falling edge, away from the DUT's sampling edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    // Half period per toggle
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/reg_renamer.sv ====
////////////////////////////////////////////////////////////////////////////
// Register renaming block, top level.
// Renames two sources and one destination at decode, records mappings at
// issue, commits or reverts at retire and rolls back on flush.
// Inputs are ignored until init_done rises.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module reg_renamer (
    input  logic                   clk,
    input  logic                   arst_n,
    output logic                   init_done,
    // Decode
    input  logic                   decode_advance,
    input  logic                   decode_uses_rd,
    input  rename_pkg::arch_addr_t decode_rd_addr,
    input  rename_pkg::arch_addr_t decode_rs_addr [rename_pkg::NUM_READ_PORTS],
    output rename_pkg::phys_addr_t decode_phys_rs_addr [rename_pkg::NUM_READ_PORTS],
    output rename_pkg::phys_addr_t decode_phys_rd_addr,
    // Issue
    input  logic                   issue_valid,
    input  logic                   issue_with_rd,
    input  rename_pkg::id_t        issue_id,
    input  rename_pkg::arch_addr_t issue_rd_addr,
    input  rename_pkg::phys_addr_t issue_phys_rd_addr,
    input  logic                   flush,
    // Retire
    input  logic                   retire_valid,
    input  rename_pkg::id_t        retire_id,
    input  logic                   retire_revert
);
    import rename_pkg::*;

    free_list_if fl_bus ();

    logic map_we;
    arch_addr_t map_waddr;
    phys_addr_t map_wdata;
    phys_addr_t prev_entry;
    logic inflight_we;
    inflight_entry_t issue_entry;
    inflight_entry_t retire_entry;

    // x0 destination gets p0 and takes nothing from the free list
    assign decode_phys_rd_addr = (decode_rd_addr != '0) ? fl_bus.head : '0;

    // Old mapping comes from the map write made at this instruction's rename
    assign issue_entry = '{
        rd_addr:   issue_rd_addr,
        spec_phys: issue_phys_rd_addr,
        prev_phys: prev_entry
    };

    ////////////////////////////////////////////////////////////////////////////
    // Control and datapath

    rename_ctrl ctrl_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .init_done      (init_done),
        .decode_advance (decode_advance),
        .decode_uses_rd (decode_uses_rd),
        .decode_rd_addr (decode_rd_addr),
        .issue_valid    (issue_valid),
        .issue_with_rd  (issue_with_rd),
        .flush          (flush),
        .issue_rd_addr  (issue_rd_addr),
        .retire_valid   (retire_valid),
        .retire_revert  (retire_revert),
        .retire_entry   (retire_entry),
        .prev_phys      (prev_entry),
        .fl             (fl_bus.ctrl),
        .map_we         (map_we),
        .map_waddr      (map_waddr),
        .map_wdata      (map_wdata),
        .inflight_we    (inflight_we)
    );

    phys_free_list #(
        .DEPTH (FREE_LIST_DEPTH)
    ) free_list_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .fl     (fl_bus.fifo)
    );

    spec_map_table map_inst (
        .clk          (clk),
        .we           (map_we),
        .waddr        (map_waddr),
        .wdata        (map_wdata),
        .rs_addr      (decode_rs_addr),
        .phys_rs_addr (decode_phys_rs_addr),
        .prev_entry   (prev_entry)
    );

    inflight_table inflight_inst (
        .clk   (clk),
        .we    (inflight_we),
        .waddr (issue_id),
        .wdata (issue_entry),
        .raddr (retire_id),
        .rdata (retire_entry)
    );

endmodule

`default_nettype wire

// ==== hdl/inflight_table.sv ====
////////////////////////////////////////////////////////////////////////////
// Table of in-flight rename records, indexed by instruction id.
// Written at issue, read asynchronously at retire.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module inflight_table (
    input  logic                        clk,
    input  logic                        we,
    input  rename_pkg::id_t             waddr,
    input  rename_pkg::inflight_entry_t wdata,
    input  rename_pkg::id_t             raddr,
    output rename_pkg::inflight_entry_t rdata
);
    import rename_pkg::*;

    // Distributed RAM, one entry per id
    inflight_entry_t ram [MAX_IDS];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[waddr] <= wdata;
        end
    end

    // Same-cycle lookup for retire
    assign rdata = ram[raddr];

endmodule

`default_nettype wire

// ==== hdl/spec_map_table.sv ====
////////////////////////////////////////////////////////////////////////////
// Speculative architectural-to-physical register map.
// Source lookups are asynchronous. Each write also captures the entry
// it overwrites into prev_entry, which issue stores and rollback uses.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module spec_map_table (
    input  logic                   clk,
    input  logic                   we,
    input  rename_pkg::arch_addr_t waddr,
    input  rename_pkg::phys_addr_t wdata,
    input  rename_pkg::arch_addr_t rs_addr [rename_pkg::NUM_READ_PORTS],
    output rename_pkg::phys_addr_t phys_rs_addr [rename_pkg::NUM_READ_PORTS],
    output rename_pkg::phys_addr_t prev_entry
);
    import rename_pkg::*;

    phys_addr_t map [NUM_ARCH_REGS];

    // Internal read port at the write address
    phys_addr_t old_entry;

    assign old_entry = map[waddr];

    ////////////////////////////////////////////////////////////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (we) begin
            map[waddr] <= wdata;
        end
    end

    // Old value of whatever was last written
    always_ff @(posedge clk) begin
        if (we) begin
            prev_entry <= old_entry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Source read ports

    // x0 reads p0, written once at init and never again
    for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_rs_read
        assign phys_rs_addr[i] = map[rs_addr[i]];
    end

endmodule

`default_nettype wire

// ==== hdl/phys_free_list.sv ====
////////////////////////////////////////////////////////////////////////////
// Circular FIFO of free physical register numbers.
// Push appends, pop removes the head, rollback re-takes the last pop
// by stepping the read pointer back. DEPTH must be a power of two.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module phys_free_list #(
    parameter int DEPTH = 32
) (
    input  logic     clk,
    input  logic     arst_n,
    free_list_if.fifo fl
);
    import rename_pkg::*;

    phys_addr_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [$clog2(DEPTH):0] rd_ptr;
    logic [$clog2(DEPTH):0] wr_ptr;
    logic empty;
    logic full;

    assign empty = (rd_ptr == wr_ptr);
    assign full = (rd_ptr[$clog2(DEPTH)] != wr_ptr[$clog2(DEPTH)])
                && (rd_ptr[$clog2(DEPTH)-1:0] == wr_ptr[$clog2(DEPTH)-1:0]);

    assign fl.head = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (fl.push) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= fl.push_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (fl.push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Popped slot is not overwritten before rollback, so stepping back is safe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (fl.rollback) begin
            rd_ptr <= rd_ptr - 1'b1;
        end else if (fl.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
        fl.pop |-> !empty)
        else $error("free list pop while empty");

    push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
        fl.push |-> !full)
        else $error("free list push while full");

endmodule

`default_nettype wire

// ==== hdl/rename_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Control of the renaming block.
// Runs the post-reset init sequence, then decodes rename, rollback,
// commit and revert into free list strobes and one map-table write.
// Map-table write priority is init, rollback, revert, rename.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rename_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic                        init_done,
    input  logic                        decode_advance,
    input  logic                        decode_uses_rd,
    input  rename_pkg::arch_addr_t      decode_rd_addr,
    input  logic                        issue_valid,
    input  logic                        issue_with_rd,
    input  logic                        flush,
    input  rename_pkg::arch_addr_t      issue_rd_addr,
    input  logic                        retire_valid,
    input  logic                        retire_revert,
    input  rename_pkg::inflight_entry_t retire_entry,
    input  rename_pkg::phys_addr_t      prev_phys,
    free_list_if.ctrl                   fl,
    output logic                        map_we,
    output rename_pkg::arch_addr_t      map_waddr,
    output rename_pkg::phys_addr_t      map_wdata,
    output logic                        inflight_we
);
    import rename_pkg::*;

    // Top bit set once all entries are loaded
    logic [ARCH_ADDR_W:0] init_cnt;
    logic init_active;
    logic rename_valid;
    logic rollback_valid;
    logic retire_act;
    logic revert_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Init sequence

    assign init_active = ~init_cnt[ARCH_ADDR_W];
    assign init_done = init_cnt[ARCH_ADDR_W];

    // Walks 0..31, then holds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_cnt <= '0;
        end else if (init_active) begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operation decode

    // x0 never renamed; a rollback takes the edge instead
    assign rename_valid = init_done & decode_advance & decode_uses_rd & ~rollback_valid
                        & (decode_rd_addr != '0);
    // Undo the rename of the instruction in issue
    assign rollback_valid = init_done & flush & issue_valid & (issue_rd_addr != '0);
    assign retire_act = init_done & retire_valid;
    assign revert_valid = retire_act & retire_revert;

    assign inflight_we = init_done & issue_with_rd;

    // Free list side
    assign fl.pop = rename_valid;
    assign fl.rollback = rollback_valid;
    assign fl.push = init_active | retire_act;
    // Init loads 32..63; revert frees the new register, commit the old one
    assign fl.push_data = init_active ? {1'b1, init_cnt[ARCH_ADDR_W-1:0]}
                        : retire_revert ? retire_entry.spec_phys
                        : retire_entry.prev_phys;

    ////////////////////////////////////////////////////////////////////////////
    // Map-table write select

    assign map_we = init_active | rollback_valid | revert_valid | rename_valid;

    always_comb begin
        // Rename by default
        map_waddr = decode_rd_addr;
        map_wdata = fl.head;
        if (init_active) begin
            // Identity mapping
            map_waddr = init_cnt[ARCH_ADDR_W-1:0];
            map_wdata = {1'b0, init_cnt[ARCH_ADDR_W-1:0]};
        end else if (rollback_valid) begin
            map_waddr = issue_rd_addr;
            map_wdata = prev_phys;
        end else if (revert_valid) begin
            map_waddr = retire_entry.rd_addr;
            map_wdata = retire_entry.prev_phys;
        end
    end

    // x0 stays pinned to p0 once init is over
    no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        (init_done && map_we) |-> (map_waddr != '0))
        else $error("map write to x0 after init");

    // Decode and retire never share a cycle
    no_retire_with_decode: assert property (@(posedge clk) disable iff (!arst_n)
        init_done |-> !(decode_advance && retire_valid))
        else $error("retire and decode advance together");

endmodule

`default_nettype wire

// ==== hdl/free_list_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Link between the rename control and the free list FIFO.
// Control side strobes push, pop and rollback; FIFO side shows its head.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface free_list_if;
    import rename_pkg::*;

    // Append push_data on this edge
    logic push;
    phys_addr_t push_data;
    // Remove head on this edge
    logic pop;
    // Re-take the last popped register
    logic rollback;
    // Oldest free register, combinational
    phys_addr_t head;

    modport ctrl (
        output push,
        output push_data,
        output pop,
        output rollback,
        input  head
    );

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        input  rollback,
        output head
    );

endinterface

`default_nettype wire

// ==== hdl/rename_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared sizing and types for the register renaming block.
// Register address widths, instruction id width and the in-flight
// record that links an issued instruction to its old and new mappings.
// Modules take these with a wildcard import in the body.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rename_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizing

    // Architectural registers, x0..x31
    localparam int NUM_ARCH_REGS = 32;
    // Physical register file
    localparam int NUM_PHYS_REGS = 64;
    // Instructions that may sit between issue and retire
    localparam int MAX_IDS = 16;
    // Source operands renamed per decode
    localparam int NUM_READ_PORTS = 2;

    localparam int ARCH_ADDR_W = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_ADDR_W = $clog2(NUM_PHYS_REGS);
    localparam int ID_W = $clog2(MAX_IDS);

    // Registers not mapped after init start out free
    localparam int FREE_LIST_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic [ARCH_ADDR_W-1:0] arch_addr_t;
    typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;
    typedef logic [ID_W-1:0] id_t;

    // One record per instruction issued with a destination
    typedef struct packed {
        arch_addr_t rd_addr;
        // Assigned at rename
        phys_addr_t spec_phys;
        // Mapping it replaced
        phys_addr_t prev_phys;
    } inflight_entry_t;

endpackage

`default_nettype wire
